// File: issuePkg.sv
package issuePkg;

    // ********************
    // bank geometry
    // ********************
    localparam int DEPTH    = 8;
    localparam int IDX_W    = $clog2(DEPTH);
    localparam int CNT_W    = $clog2(DEPTH + 1);

    // ********************
    // datapath widths
    // ********************
    localparam int PREG_W   = 6;
    localparam int ROB_W    = 5;
    localparam int DATA_W   = 16;

    // external writeback ports plus the internal one from the wakeup pipe
    localparam int EXT_WAKE = 2;
    localparam int WAKE_NUM = EXT_WAKE + 1;

    // cycles from issue to internal wakeup
    localparam int EXEC_LAT = 2;

    typedef logic [PREG_W-1:0] pregT;
    // top bit is the wrap direction
    typedef logic [ROB_W:0]    robIdxT;
    typedef logic [IDX_W-1:0]  slotT;
    typedef logic [CNT_W-1:0]  cntT;
    typedef logic [DATA_W-1:0] payloadT;

    // wrap-aware age test, true when entry is older than the redirect point
    function automatic logic isOlder(robIdxT entry, robIdxT redir);
        logic dirDiff;
        logic idxGreater;
        dirDiff    = entry[ROB_W] ^ redir[ROB_W];
        idxGreater = redir[ROB_W-1:0] > entry[ROB_W-1:0];
        return dirDiff ^ idxGreater;
    endfunction

endpackage

// File: payloadRam.sv
`timescale 1ns/1ns

module payloadRam
    import issuePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    we_i,
    input  slotT    waddr_i,
    input  payloadT wdata_i,
    input  logic    re_i,
    input  slotT    raddr_i,
    output payloadT rdata_o
);

    payloadT mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, held while re_i is low
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rdata_o <= '0;
        end else if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// File: ageSelector.sv
`timescale 1ns/1ns

module ageSelector
    import issuePkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_i,
    input  slotT             allocSlot_i,
    input  logic [DEPTH-1:0] req_i,
    output logic [DEPTH-1:0] grant_o
);

    // ********************
    // age matrix
    // ********************
    // olderM[i][j] set means slot j was allocated before slot i
    logic [DEPTH-1:0] olderM [DEPTH];
    logic [DEPTH-1:0] allocOh;

    assign allocOh = {{(DEPTH-1){1'b0}}, 1'b1} << allocSlot_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                olderM[i] <= '0;
            end
        end else if (alloc_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (allocOh[i]) begin
                    // new slot is younger than everything else
                    olderM[i] <= ~allocOh;
                end else begin
                    olderM[i][allocSlot_i] <= 1'b0;
                end
            end
        end
    end

    // ********************
    // oldest request
    // ********************
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            // no other requester is older than slot i
            grant_o[i] = req_i[i] & ~(|(olderM[i] & req_i));
        end
    end

endmodule

// File: wakeupPipe.sv
`timescale 1ns/1ns

module wakeupPipe
    import issuePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic issueValid_i,
    input  logic issueWe_i,
    input  pregT issueRd_i,
    output logic wakeEn_o,
    output pregT wakeRd_o
);

    // one stage per cycle of the functional unit
    logic [EXEC_LAT-1:0] vldQ;
    pregT                tagQ [EXEC_LAT];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vldQ <= '0;
        end else begin
            // only ops that write a register produce a wakeup
            vldQ[0] <= issueValid_i & issueWe_i;
            for (int s = 1; s < EXEC_LAT; s++) begin
                vldQ[s] <= vldQ[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tagQ[0] <= issueRd_i;
        for (int s = 1; s < EXEC_LAT; s++) begin
            tagQ[s] <= tagQ[s-1];
        end
    end

    assign wakeEn_o = vldQ[EXEC_LAT-1];
    assign wakeRd_o = tagQ[EXEC_LAT-1];

endmodule

// File: issueBank.sv
`timescale 1ns/1ns

module issueBank
    import issuePkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                dispEn_i,
    input  pregT                dispSrc1_i,
    input  logic                dispSrc1Rdy_i,
    input  pregT                dispSrc2_i,
    input  logic                dispSrc2Rdy_i,
    input  pregT                dispRd_i,
    input  logic                dispWe_i,
    input  robIdxT              dispRob_i,
    input  payloadT             dispData_i,
    input  logic [WAKE_NUM-1:0] wakeEn_i,
    input  pregT [WAKE_NUM-1:0] wakeRd_i,
    input  logic                execReady_i,
    input  logic                redirect_i,
    input  robIdxT              redirectRob_i,
    output logic                full_o,
    output cntT                 count_o,
    output logic                issueValid_o,
    output pregT                issueSrc1_o,
    output pregT                issueSrc2_o,
    output pregT                issueRd_o,
    output logic                issueWe_o,
    output robIdxT              issueRob_o,
    output payloadT             issueData_o
);

    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] src1Rdy;
    logic [DEPTH-1:0] src2Rdy;
    logic [DEPTH-1:0] weQ;
    pregT             src1Q [DEPTH];
    pregT             src2Q [DEPTH];
    pregT             rdQ   [DEPTH];
    robIdxT           robQ  [DEPTH];

    logic [DEPTH-1:0] hit1;
    logic [DEPTH-1:0] hit2;
    logic             dispHit1;
    logic             dispHit2;
    logic [DEPTH-1:0] readyVec;
    logic [DEPTH-1:0] grant;
    logic [DEPTH-1:0] keepVec;
    logic [DEPTH-1:0] allocOh;
    logic [DEPTH-1:0] freeVec;
    slotT             freeSlot;
    slotT             selSlot;
    logic             dispOk;
    logic             issueFire;

    // ********************
    // free slot and occupancy
    // ********************
    always_comb begin
        freeSlot = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                freeSlot = slotT'(i);
            end
        end
    end

    always_comb begin
        count_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            count_o = count_o + cntT'(valid[i]);
        end
    end

    assign full_o = &valid;
    // a dispatch during redirect survives only if it is older than the redirect point
    assign dispOk = dispEn_i & ~full_o & (~redirect_i | isOlder(dispRob_i, redirectRob_i));
    assign allocOh = {{(DEPTH-1){1'b0}}, dispOk} << freeSlot;

    // ********************
    // tag match wakeup
    // ********************
    always_comb begin
        hit1     = '0;
        hit2     = '0;
        dispHit1 = 1'b0;
        dispHit2 = 1'b0;
        for (int k = 0; k < WAKE_NUM; k++) begin
            if (wakeEn_i[k] && (wakeRd_i[k] == dispSrc1_i)) begin
                dispHit1 = 1'b1;
            end
            if (wakeEn_i[k] && (wakeRd_i[k] == dispSrc2_i)) begin
                dispHit2 = 1'b1;
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (wakeEn_i[k] && (wakeRd_i[k] == src1Q[i])) begin
                    hit1[i] = 1'b1;
                end
                if (wakeEn_i[k] && (wakeRd_i[k] == src2Q[i])) begin
                    hit2[i] = 1'b1;
                end
            end
        end
    end

    // ********************
    // select and redirect
    // ********************
    assign readyVec  = valid & src1Rdy & src2Rdy;
    assign issueFire = (|readyVec) & execReady_i & ~redirect_i;
    assign freeVec   = grant & {DEPTH{issueFire}};

    always_comb begin
        selSlot = '0;
        for (int i = 0; i < DEPTH; i++) begin
            keepVec[i] = ~redirect_i | isOlder(robQ[i], redirectRob_i);
            if (grant[i]) begin
                selSlot = selSlot | slotT'(i);
            end
        end
    end

    ageSelector ageSelector_i (
        .clk         (clk),
        .rst         (rst),
        .alloc_i     (dispOk),
        .allocSlot_i (freeSlot),
        .req_i       (readyVec),
        .grant_o     (grant)
    );

    // control state
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid        <= '0;
            src1Rdy      <= '0;
            src2Rdy      <= '0;
            issueValid_o <= 1'b0;
        end else begin
            valid        <= (valid & keepVec & ~freeVec) | allocOh;
            issueValid_o <= issueFire;
            for (int i = 0; i < DEPTH; i++) begin
                if (allocOh[i]) begin
                    src1Rdy[i] <= dispSrc1Rdy_i | dispHit1;
                    src2Rdy[i] <= dispSrc2Rdy_i | dispHit2;
                end else begin
                    src1Rdy[i] <= src1Rdy[i] | hit1[i];
                    src2Rdy[i] <= src2Rdy[i] | hit2[i];
                end
            end
        end
    end

    // entry fields and issue registers
    always_ff @(posedge clk) begin
        if (dispOk) begin
            src1Q[freeSlot] <= dispSrc1_i;
            src2Q[freeSlot] <= dispSrc2_i;
            rdQ[freeSlot]   <= dispRd_i;
            weQ[freeSlot]   <= dispWe_i;
            robQ[freeSlot]  <= dispRob_i;
        end
        if (issueFire) begin
            issueSrc1_o <= src1Q[selSlot];
            issueSrc2_o <= src2Q[selSlot];
            issueRd_o   <= rdQ[selSlot];
            issueWe_o   <= weQ[selSlot];
            issueRob_o  <= robQ[selSlot];
        end
    end

    payloadRam payloadRam_i (
        .clk     (clk),
        .rst     (rst),
        .we_i    (dispOk),
        .waddr_i (freeSlot),
        .wdata_i (dispData_i),
        .re_i    (issueFire),
        .raddr_i (selSlot),
        .rdata_o (issueData_o)
    );

endmodule

// File: issueUnit.sv
`timescale 1ns/1ns

module issueUnit
    import issuePkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                dispEn_i,
    input  pregT                dispSrc1_i,
    input  logic                dispSrc1Rdy_i,
    input  pregT                dispSrc2_i,
    input  logic                dispSrc2Rdy_i,
    input  pregT                dispRd_i,
    input  logic                dispWe_i,
    input  robIdxT              dispRob_i,
    input  payloadT             dispData_i,
    output logic                full_o,
    output cntT                 count_o,
    input  logic [EXT_WAKE-1:0] wakeEn_i,
    input  pregT [EXT_WAKE-1:0] wakeRd_i,
    input  logic                execReady_i,
    input  logic                redirect_i,
    input  robIdxT              redirectRob_i,
    output logic                issueValid_o,
    output pregT                issueSrc1_o,
    output pregT                issueSrc2_o,
    output pregT                issueRd_o,
    output logic                issueWe_o,
    output robIdxT              issueRob_o,
    output payloadT             issueData_o
);

    // internal wakeup port, top index of the bank's wakeup bus
    logic intWakeEn;
    pregT intWakeRd;

    issueBank issueBank_i (
        .clk           (clk),
        .rst           (rst),
        .dispEn_i      (dispEn_i),
        .dispSrc1_i    (dispSrc1_i),
        .dispSrc1Rdy_i (dispSrc1Rdy_i),
        .dispSrc2_i    (dispSrc2_i),
        .dispSrc2Rdy_i (dispSrc2Rdy_i),
        .dispRd_i      (dispRd_i),
        .dispWe_i      (dispWe_i),
        .dispRob_i     (dispRob_i),
        .dispData_i    (dispData_i),
        .wakeEn_i      ({intWakeEn, wakeEn_i}),
        .wakeRd_i      ({intWakeRd, wakeRd_i}),
        .execReady_i   (execReady_i),
        .redirect_i    (redirect_i),
        .redirectRob_i (redirectRob_i),
        .full_o        (full_o),
        .count_o       (count_o),
        .issueValid_o  (issueValid_o),
        .issueSrc1_o   (issueSrc1_o),
        .issueSrc2_o   (issueSrc2_o),
        .issueRd_o     (issueRd_o),
        .issueWe_o     (issueWe_o),
        .issueRob_o    (issueRob_o),
        .issueData_o   (issueData_o)
    );

    wakeupPipe wakeupPipe_i (
        .clk          (clk),
        .rst          (rst),
        .issueValid_i (issueValid_o),
        .issueWe_i    (issueWe_o),
        .issueRd_i    (issueRd_o),
        .wakeEn_o     (intWakeEn),
        .wakeRd_o     (intWakeRd)
    );

endmodule

// File: issueUnit_assert.sv
`timescale 1ns/1ns

module issueUnit_assert
    import issuePkg::*;
(
    input logic clk,
    input logic rst,
    input logic dispEn_i,
    input logic full_o,
    input cntT  count_o,
    input logic execReady_i,
    input logic redirect_i,
    input logic issueValid_o
);

    // ********************
    // bank port invariants
    // ********************
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (!rst)
        full_o |-> !dispEn_i)
        else $error("dispatch raised while the bank is full");

    // a redirect cycle never issues
    quietAfterRedirect: assert property (@(posedge clk) disable iff (!rst)
        redirect_i |=> !issueValid_o)
        else $error("issue in the cycle after a redirect");

    // occupancy stays within the bank and agrees with the full flag
    countInRange: assert property (@(posedge clk) disable iff (!rst)
        (count_o <= cntT'(DEPTH)) && (full_o == (count_o == cntT'(DEPTH))))
        else $error("occupancy count out of range or disagrees with the full flag");

    noIssueWhenStalled: assert property (@(posedge clk) disable iff (!rst)
        !execReady_i |=> !issueValid_o)
        else $error("issue while the execution side was not ready");

endmodule

bind issueBank issueUnit_assert issueUnitAssert_i (
    .clk          (clk),
    .rst          (rst),
    .dispEn_i     (dispEn_i),
    .full_o       (full_o),
    .count_o      (count_o),
    .execReady_i  (execReady_i),
    .redirect_i   (redirect_i),
    .issueValid_o (issueValid_o)
);

// File: issueUnitTb.sv
`timescale 1ns/1ns

module issueUnitTb
    import issuePkg::*;
();

    logic                clk;
    logic                rst;
    logic                dispEn;
    pregT                dispSrc1;
    logic                dispSrc1Rdy;
    pregT                dispSrc2;
    logic                dispSrc2Rdy;
    pregT                dispRd;
    logic                dispWe;
    robIdxT              dispRob;
    payloadT             dispData;
    logic [EXT_WAKE-1:0] wakeEn;
    pregT [EXT_WAKE-1:0] wakeRd;
    logic                execReady;
    logic                redirect;
    robIdxT              redirectRob;
    logic                full;
    cntT                 count;
    logic                issueValid;
    pregT                issueSrc1;
    pregT                issueSrc2;
    pregT                issueRd;
    logic                issueWe;
    robIdxT              issueRob;
    payloadT             issueData;

    // ********************
    // model state
    // ********************
    logic    mValid [DEPTH];
    logic    mRdy1  [DEPTH];
    logic    mRdy2  [DEPTH];
    pregT    mSrc1  [DEPTH];
    pregT    mSrc2  [DEPTH];
    pregT    mRd    [DEPTH];
    logic    mWe    [DEPTH];
    robIdxT  mRob   [DEPTH];
    payloadT mData  [DEPTH];
    int      mAge   [DEPTH];
    int      ageSeq;
    // issued destinations on their way back as internal wakeups
    logic    pipeV   [EXEC_LAT+1];
    pregT    pipeTag [EXEC_LAT+1];

    logic    expValid;
    pregT    expSrc1;
    pregT    expSrc2;
    pregT    expRd;
    logic    expWe;
    robIdxT  expRob;
    payloadT expData;
    cntT     expCount;

    int      errCount;
    string   testName;

    issueUnit issueUnit_i (
        .clk           (clk),
        .rst           (rst),
        .dispEn_i      (dispEn),
        .dispSrc1_i    (dispSrc1),
        .dispSrc1Rdy_i (dispSrc1Rdy),
        .dispSrc2_i    (dispSrc2),
        .dispSrc2Rdy_i (dispSrc2Rdy),
        .dispRd_i      (dispRd),
        .dispWe_i      (dispWe),
        .dispRob_i     (dispRob),
        .dispData_i    (dispData),
        .full_o        (full),
        .count_o       (count),
        .wakeEn_i      (wakeEn),
        .wakeRd_i      (wakeRd),
        .execReady_i   (execReady),
        .redirect_i    (redirect),
        .redirectRob_i (redirectRob),
        .issueValid_o  (issueValid),
        .issueSrc1_o   (issueSrc1),
        .issueSrc2_o   (issueSrc2),
        .issueRd_o     (issueRd),
        .issueWe_o     (issueWe),
        .issueRob_o    (issueRob),
        .issueData_o   (issueData)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ********************
    // reference rules
    // ********************
    // oldest valid entry with both sources ready or -1 if there is none
    function automatic int oldestReady();
        int best;
        best = -1;
        for (int i = 0; i < DEPTH; i++) begin
            if (mValid[i] && mRdy1[i] && mRdy2[i]) begin
                if (best < 0 || mAge[i] < mAge[slotT'(best)]) begin
                    best = i;
                end
            end
        end
        return best;
    endfunction

    // a smaller field is older within one wrap and a larger or equal one across a wrap
    function automatic logic olderThan(robIdxT entry, robIdxT redir);
        if (entry[ROB_W] == redir[ROB_W]) begin
            return entry[ROB_W-1:0] < redir[ROB_W-1:0];
        end
        return entry[ROB_W-1:0] >= redir[ROB_W-1:0];
    endfunction

    function automatic logic wakeMatch(pregT tag, logic intV, pregT intTag);
        logic hit;
        hit = intV && (intTag == tag);
        for (int k = 0; k < EXT_WAKE; k++) begin
            if (wakeEn[k] && (wakeRd[k] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // model steps on the same edge and reads the values the DUT samples
    always @(posedge clk) begin
        int   sel;
        int   slot;
        logic intV;
        pregT intTag;
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mValid[i] = 1'b0;
            end
            for (int s = 0; s <= EXEC_LAT; s++) begin
                pipeV[s] = 1'b0;
            end
            expValid = 1'b0;
            expCount = '0;
            ageSeq   = 0;
        end else begin
            intV   = pipeV[EXEC_LAT];
            intTag = pipeTag[EXEC_LAT];
            sel    = oldestReady();
            slot   = -1;
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (!mValid[i]) begin
                    slot = i;
                end
            end
            expValid = (sel >= 0) && execReady && !redirect;
            if (expValid) begin
                expSrc1 = mSrc1[slotT'(sel)];
                expSrc2 = mSrc2[slotT'(sel)];
                expRd   = mRd[slotT'(sel)];
                expWe   = mWe[slotT'(sel)];
                expRob  = mRob[slotT'(sel)];
                expData = mData[slotT'(sel)];
                mValid[slotT'(sel)] = 1'b0;
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (redirect && !olderThan(mRob[i], redirectRob)) begin
                    mValid[i] = 1'b0;
                end
                mRdy1[i] = mRdy1[i] | wakeMatch(mSrc1[i], intV, intTag);
                mRdy2[i] = mRdy2[i] | wakeMatch(mSrc2[i], intV, intTag);
            end
            if (dispEn && slot >= 0 && (!redirect || olderThan(dispRob, redirectRob))) begin
                mValid[slotT'(slot)] = 1'b1;
                mSrc1[slotT'(slot)]  = dispSrc1;
                mSrc2[slotT'(slot)]  = dispSrc2;
                mRdy1[slotT'(slot)]  = dispSrc1Rdy | wakeMatch(dispSrc1, intV, intTag);
                mRdy2[slotT'(slot)]  = dispSrc2Rdy | wakeMatch(dispSrc2, intV, intTag);
                mRd[slotT'(slot)]    = dispRd;
                mWe[slotT'(slot)]    = dispWe;
                mRob[slotT'(slot)]   = dispRob;
                mData[slotT'(slot)]  = dispData;
                mAge[slotT'(slot)]   = ageSeq;
                ageSeq++;
            end
            for (int s = EXEC_LAT; s > 0; s--) begin
                pipeV[s]   = pipeV[s-1];
                pipeTag[s] = pipeTag[s-1];
            end
            pipeV[0]   = expValid && expWe;
            pipeTag[0] = expRd;
            expCount = '0;
            for (int i = 0; i < DEPTH; i++) begin
                expCount = expCount + cntT'(mValid[i]);
            end
        end
    end

    // ********************
    // compare
    // ********************
    task automatic checkTag(string what, pregT exp, pregT act);
        if (act !== exp) begin
            errCount++;
            $display("error %s %s: expected %0d, actual %0d", testName, what, exp, act);
        end
    endtask

    task automatic checkRob(string what, robIdxT exp, robIdxT act);
        if (act !== exp) begin
            errCount++;
            $display("error %s %s: expected %0h, actual %0h", testName, what, exp, act);
        end
    endtask

    task automatic checkData(string what, payloadT exp, payloadT act);
        if (act !== exp) begin
            errCount++;
            $display("error %s %s: expected %04h, actual %04h", testName, what, exp, act);
        end
    endtask

    task automatic checkCnt(string what, cntT exp, cntT act);
        if (act !== exp) begin
            errCount++;
            $display("error %s %s: expected %0d, actual %0d", testName, what, exp, act);
        end
    endtask

    task automatic checkBit(string what, logic exp, logic act);
        if (act !== exp) begin
            errCount++;
            $display("error %s %s: expected %b, actual %b", testName, what, exp, act);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            checkBit("issueValid", expValid, issueValid);
            if (expValid) begin
                checkTag("issueSrc1", expSrc1, issueSrc1);
                checkTag("issueSrc2", expSrc2, issueSrc2);
                checkTag("issueRd", expRd, issueRd);
                checkBit("issueWe", expWe, issueWe);
                checkRob("issueRob", expRob, issueRob);
                checkData("issueData", expData, issueData);
            end
            checkCnt("count", expCount, count);
            checkBit("full", expCount == cntT'(DEPTH), full);
        end
    end

    // ********************
    // stimulus
    // ********************
    task automatic nextCycle();
        @(posedge clk);
        dispEn   <= 1'b0;
        wakeEn   <= '0;
        redirect <= 1'b0;
    endtask

    task automatic dispatchOp(pregT s1, logic r1, pregT s2, logic r2, pregT rd, logic we,
                              robIdxT rob);
        nextCycle();
        dispEn      <= 1'b1;
        dispSrc1    <= s1;
        dispSrc1Rdy <= r1;
        dispSrc2    <= s2;
        dispSrc2Rdy <= r2;
        dispRd      <= rd;
        dispWe      <= we;
        dispRob     <= rob;
        dispData    <= payloadT'($urandom);
    endtask

    task automatic wakeTag(logic [EXT_WAKE-1:0] ports, pregT tag);
        nextCycle();
        wakeEn <= ports;
        wakeRd <= {EXT_WAKE{tag}};
    endtask

    task automatic setExecReady(logic value);
        nextCycle();
        execReady <= value;
    endtask

    task automatic redirectTo(robIdxT rob);
        nextCycle();
        redirect    <= 1'b1;
        redirectRob <= rob;
    endtask

    task automatic waitDrain(int limit);
        int n;
        n = 0;
        nextCycle();
        @(negedge clk);
        while (count != '0 && n < limit) begin
            nextCycle();
            @(negedge clk);
            n++;
        end
        if (count != '0) begin
            errCount++;
            $display("timeout in %s: the bank never emptied", testName);
        end
        // let the internal wakeups of the last issues pass
        repeat (EXEC_LAT + 2) nextCycle();
    endtask

    initial begin
        void'($urandom(32'ha63b_3e07));
        errCount    = 0;
        testName    = "reset";
        rst         = 1'b0;
        dispEn      = 1'b0;
        dispSrc1    = '0;
        dispSrc1Rdy = 1'b0;
        dispSrc2    = '0;
        dispSrc2Rdy = 1'b0;
        dispRd      = '0;
        dispWe      = 1'b0;
        dispRob     = '0;
        dispData    = '0;
        wakeEn      = '0;
        wakeRd      = '0;
        execReady   = 1'b1;
        redirect    = 1'b0;
        redirectRob = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;

        testName = "readyIssue";
        dispatchOp(6'd1, 1'b1, 6'd2, 1'b1, 6'd3, 1'b1, 6'd1);
        waitDrain(20);

        // producer of p10, its consumer, and a consumer of that one
        testName = "wakeup";
        dispatchOp(6'd4, 1'b1, 6'd5, 1'b1, 6'd10, 1'b1, 6'd2);
        dispatchOp(6'd10, 1'b0, 6'd20, 1'b0, 6'd11, 1'b1, 6'd3);
        dispatchOp(6'd11, 1'b0, 6'd5, 1'b1, 6'd12, 1'b0, 6'd4);
        wakeTag(2'b10, 6'd20);
        waitDrain(40);

        // slot reuse makes age order differ from slot order
        testName = "issueOrder";
        dispatchOp(6'd1, 1'b1, 6'd2, 1'b1, 6'd12, 1'b0, 6'd5);
        for (int i = 0; i < 4; i++) begin
            dispatchOp(6'd30, 1'b0, 6'd2, 1'b1, 6'd13, 1'b0, robIdxT'(6 + i));
        end
        wakeTag(2'b01, 6'd30);
        waitDrain(30);

        testName = "full";
        setExecReady(1'b0);
        for (int i = 0; i < DEPTH; i++) begin
            dispatchOp(6'd1, 1'b1, 6'd2, 1'b1, 6'd14, 1'b0, robIdxT'(10 + i));
        end
        nextCycle();
        @(negedge clk);
        checkCnt("fullCount", cntT'(DEPTH), count);
        checkBit("fullFlag", 1'b1, full);

        testName = "backPressure";
        setExecReady(1'b1);
        setExecReady(1'b0);
        dispatchOp(6'd41, 1'b0, 6'd2, 1'b1, 6'd15, 1'b1, 6'd20);
        // wakeup of p41 arrives in the dispatch cycle itself
        wakeEn <= 2'b11;
        wakeRd <= {EXT_WAKE{6'd41}};
        repeat (5) nextCycle();
        setExecReady(1'b1);
        waitDrain(40);

        // redirect point sits just past a wrap of the ROB
        testName = "redirect";
        dispatchOp(6'd50, 1'b0, 6'd2, 1'b1, 6'd16, 1'b0, 6'b0_11110);
        dispatchOp(6'd50, 1'b0, 6'd2, 1'b1, 6'd16, 1'b0, 6'b0_11111);
        dispatchOp(6'd50, 1'b0, 6'd2, 1'b1, 6'd16, 1'b0, 6'b1_00000);
        dispatchOp(6'd50, 1'b0, 6'd2, 1'b1, 6'd16, 1'b0, 6'b1_00001);
        dispatchOp(6'd50, 1'b0, 6'd2, 1'b1, 6'd16, 1'b0, 6'b1_00010);
        dispatchOp(6'd50, 1'b0, 6'd2, 1'b1, 6'd16, 1'b0, 6'b1_00101);
        redirectTo(6'b1_00010);
        wakeTag(2'b01, 6'd50);
        @(negedge clk);
        checkCnt("keptCount", cntT'(4), count);
        waitDrain(30);

        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: build.f
issuePkg.sv
payloadRam.sv
ageSelector.sv
wakeupPipe.sv
issueBank.sv
issueUnit.sv
issueUnit_assert.sv
issueUnitTb.sv

// File: run.sh
#!/bin/sh
# compile and run the issue unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module issueUnitTb -f build.f -o issueUnitSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/issueUnitSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
